//--- src.f
pce_pad_pkg.sv
pad_scan_if.sv
pad_scan_fsm.sv
turbo_timer.sv
pad_encoder.sv
pad_mux_latch.sv
pce_pad_top.sv
pce_pad_properties.sv
tb_pce_pad.sv

//--- Makefile
# Verilator build for the pad controller testbench

VERILATOR ?= verilator
TOP       ?= tb_pce_pad
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_pce_pad.sv
module tb_pce_pad;
  timeunit 1ns;
  timeprecision 1ps;

  // one table row: pads p4..p1, settings, console lines, expected nibble
  typedef struct packed {
    logic [47:0] pads;
    logic        tap;
    logic        b6;
    logic [1:0]  spd1;
    logic [1:0]  spd2;
    logic [1:0]  jo;
    logic [3:0]  expect_nib;
  } entry_t;

  logic        clk_sys_42_95 = 1'b0;
  logic        reset = 1'b1;
  logic [11:0] p1_buttons = '0;
  logic [11:0] p2_buttons = '0;
  logic [11:0] p3_buttons = '0;
  logic [11:0] p4_buttons = '0;
  logic        turbo_tap_enable = 1'b0;
  logic        button6_enable = 1'b0;
  logic [1:0]  button1_turbo_speed = '0;
  logic [1:0]  button2_turbo_speed = '0;
  logic [1:0]  joy_out = '0;
  logic [3:0]  joy_in;

  entry_t table_q[$];
  integer seed = 32'h25278f93;
  // reference scan state
  logic [2:0]  m_port = '0;
  logic        m_bank = 1'b0;
  logic [3:0]  m_frame = '0;
  logic        m_clear_prev = 1'b0;
  logic        m_sel_prev = 1'b0;

  pce_pad_top u_pce_pad_top (
    .clk_sys_42_95       (clk_sys_42_95),
    .reset               (reset),
    .p1_buttons          (p1_buttons),
    .p2_buttons          (p2_buttons),
    .p3_buttons          (p3_buttons),
    .p4_buttons          (p4_buttons),
    .turbo_tap_enable    (turbo_tap_enable),
    .button6_enable      (button6_enable),
    .button1_turbo_speed (button1_turbo_speed),
    .button2_turbo_speed (button2_turbo_speed),
    .joy_out             (joy_out),
    .joy_in              (joy_in)
  );

  always #5 clk_sys_42_95 = ~clk_sys_42_95;

  // two cycles of reset
  initial begin
    repeat (2) @(posedge clk_sys_42_95);
    reset <= 1'b0;
  end

  // gate level per speed code: 1 slow, 2 fast, else open
  function automatic logic gate_level(input logic [1:0] spd, input logic [3:0] frame);
    gate_level = (spd == 2'd1) ? frame[2] : (spd == 2'd2) ? frame[1] : 1'b1;
  endfunction

  // nibble the console should see for one port, bank and select level
  function automatic logic [3:0] expected_nibble(input logic [47:0] pads, input entry_t e);
    logic [11:0] b;
    logic        fi;
    logic        fii;
    logic [15:0] w;
    b   = pads[m_port[1:0]*12 +: 12];
    fi  = b[4] | (~e.b6 & gate_level(e.spd1, m_frame) & b[8]);
    fii = b[5] | (~e.b6 & gate_level(e.spd2, m_frame) & b[9]);
    w   = {4'h0, ~{b[11], b[10], b[9], b[8]}, ~{b[1], b[2], b[0], b[3]},
           ~{b[7], b[6], fii, fi}};
    // unpopulated tap ports
    if (m_port >= 3'd4) w = 16'h0FFF;
    expected_nibble = w[{m_bank, e.jo[0]}*4 +: 4];
  endfunction

  // builds one row, advances the reference scan state, stores the expected nibble
  task automatic add_entry(input logic tap, input logic b6, input logic [1:0] s1,
                           input logic [1:0] s2, input logic [1:0] jo, input logic turbo_pat);
    entry_t      e;
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $random(seed);
    r1 = $random(seed);
    e = '{pads: {r1[15:0], r0}, tap: tap, b6: b6, spd1: s1, spd2: s2, jo: jo,
          expect_nib: 4'h0};
    // pad 1 holds III with I released
    if (turbo_pat) begin
      e.pads[4] = 1'b0;
      e.pads[8] = 1'b1;
    end
    if (jo[1] && !m_clear_prev) begin
      m_bank  = b6 ? ~m_bank : 1'b0;
      m_frame = m_frame + 4'd1;
    end
    if (jo[1]) m_port = '0;
    else if (jo[0] && !m_sel_prev && tap) m_port = m_port + 3'd1;
    m_clear_prev = jo[1];
    m_sel_prev   = jo[0];
    e.expect_nib = jo[1] ? 4'h0 : expected_nibble(e.pads, e);
    table_q.push_back(e);
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // polled between edges, so joy_in still holds its reset value on exit
  task automatic wait_reset_release(input int limit);
    int cycles;
    cycles = 0;
    while (reset) begin
      if (cycles >= limit) begin
        $display("reset stayed asserted for %0d cycles", limit);
        $display("Test failures found");
        $fatal(1);
      end else begin
        @(negedge clk_sys_42_95);
        cycles++;
      end
    end
  endtask

  // drive one row, hold it four cycles, check between edges
  task automatic apply_entry(input entry_t e);
    @(posedge clk_sys_42_95);
    {p4_buttons, p3_buttons, p2_buttons, p1_buttons} <= e.pads;
    turbo_tap_enable    <= e.tap;
    button6_enable      <= e.b6;
    button1_turbo_speed <= e.spd1;
    button2_turbo_speed <= e.spd2;
    joy_out             <= e.jo;
    repeat (4) @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
    compare_value("joy_in", 32'(joy_in), 32'(e.expect_nib));
  endtask

  initial begin
    // dir and low bank, tap off
    add_entry(1'b0, 1'b0, 2'd0, 2'd0, 2'b11, 1'b0);
    for (int i = 0; i < 3; i++) begin
      add_entry(1'b0, 1'b0, 2'd0, 2'd0, 2'b01, 1'b0);
      add_entry(1'b0, 1'b0, 2'd0, 2'd0, 2'b00, 1'b0);
    end
    // multitap walk through all eight ports, both bank settings
    for (int b = 0; b < 2; b++) begin
      add_entry(1'b1, 1'(b), 2'd0, 2'd0, 2'b11, 1'b0);
      for (int i = 0; i < 9; i++) begin
        add_entry(1'b1, 1'(b), 2'd0, 2'd0, 2'b01, 1'b0);
        add_entry(1'b1, 1'(b), 2'd0, 2'd0, 2'b00, 1'b0);
      end
    end
    // six-button bank toggle per frame
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 1'b1, 2'd0, 2'd0, 2'b11, 1'b0);
      add_entry(1'b0, 1'b1, 2'd0, 2'd0, 2'b00, 1'b0);
      add_entry(1'b0, 1'b1, 2'd0, 2'd0, 2'b01, 1'b0);
    end
    // turbo slow, fast and off; ignored in six-button mode
    for (int i = 0; i < 40; i++) begin
      add_entry(1'b0, i >= 34, 2'(i / 10 + 1), 2'(i / 10 + 1), 2'b11, 1'b1);
      add_entry(1'b0, i >= 34, 2'(i / 10 + 1), 2'(i / 10 + 1), 2'b00, 1'b1);
    end
    wait_reset_release(20);
    compare_value("joy_in", 32'(joy_in), 32'h0);
    foreach (table_q[i]) apply_entry(table_q[i]);
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- pce_pad_properties.sv
module pce_pad_properties (
  input logic       clk_sys_42_95,
  input logic       reset,
  input logic [1:0] joy_out,
  input logic [3:0] joy_in,
  input logic [2:0] port_sel,
  input logic       high_bank,
  input logic       dir_sel,
  input logic       clear_level
);
  timeunit 1ns;
  timeprecision 1ps;

  // clear pin high, two edges later the nibble reads zero
  assert property (@(posedge clk_sys_42_95) disable iff (reset)
    joy_out[1] |-> ##2 (joy_in == 4'h0))
    else $error("joy_in not zero while clear held");

  assert property (@(posedge clk_sys_42_95) reset |=> (joy_in == 4'h0))
    else $error("joy_in not zero after reset");

  // idle port shows F except the zero id nibble
  assert property (@(posedge clk_sys_42_95) disable iff (reset)
    (port_sel >= 3'd4 && !clear_level)
      |=> (joy_in == ($past(high_bank && dir_sel) ? 4'h0 : 4'hF)))
    else $error("idle port nibble leaked into joy_in");

endmodule

bind pce_pad_top pce_pad_properties u_pce_pad_properties (
  .clk_sys_42_95 (clk_sys_42_95),
  .reset         (reset),
  .joy_out       (joy_out),
  .joy_in        (joy_in),
  .port_sel      (scan.port_sel),
  .high_bank     (scan.high_bank),
  .dir_sel       (scan.dir_sel),
  .clear_level   (scan.clear_level)
);

//--- pce_pad_top.sv
module pce_pad_top (
  input  logic                                  clk_sys_42_95,
  input  logic                                  reset,
  input  logic [pce_pad_pkg::pad_buttons_w-1:0] p1_buttons,
  input  logic [pce_pad_pkg::pad_buttons_w-1:0] p2_buttons,
  input  logic [pce_pad_pkg::pad_buttons_w-1:0] p3_buttons,
  input  logic [pce_pad_pkg::pad_buttons_w-1:0] p4_buttons,
  input  logic                                  turbo_tap_enable,
  input  logic                                  button6_enable,
  input  logic [1:0]                            button1_turbo_speed,
  input  logic [1:0]                            button2_turbo_speed,
  // bit 1 clear, bit 0 select
  input  logic [1:0]                            joy_out,
  output logic [pce_pad_pkg::nibble_w-1:0]      joy_in
);
  import pce_pad_pkg::*;

  logic frame_start;
  logic turbo_gate_i;
  logic turbo_gate_ii;

  // pads in tap port order
  logic [pad_buttons_w-1:0] pad_buttons [num_pads];
  pad_word_t                pad_words [num_pads];

  assign pad_buttons[0] = p1_buttons;
  assign pad_buttons[1] = p2_buttons;
  assign pad_buttons[2] = p3_buttons;
  assign pad_buttons[3] = p4_buttons;

  // scan state shared by fsm and latch
  pad_scan_if scan ();

  pad_scan_fsm u_scan_fsm (
    .clk_sys_42_95    (clk_sys_42_95),
    .reset            (reset),
    .turbo_tap_enable (turbo_tap_enable),
    .button6_enable   (button6_enable),
    .joy_out          (joy_out),
    .frame_start      (frame_start),
    .scan             (scan.fsm)
  );

  turbo_timer u_turbo_timer (
    .clk_sys_42_95       (clk_sys_42_95),
    .reset               (reset),
    .frame_start         (frame_start),
    .button1_turbo_speed (button1_turbo_speed),
    .button2_turbo_speed (button2_turbo_speed),
    .turbo_gate_i        (turbo_gate_i),
    .turbo_gate_ii       (turbo_gate_ii)
  );

  // one encoder per pad
  for (genvar p = 0; p < num_pads; p++) begin : g_pad
    pad_encoder u_pad_encoder (
      .buttons        (pad_buttons[p]),
      .button6_enable (button6_enable),
      .turbo_gate_i   (turbo_gate_i),
      .turbo_gate_ii  (turbo_gate_ii),
      .pad_word       (pad_words[p])
    );
  end

  pad_mux_latch u_mux_latch (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .pad_words     (pad_words),
    .scan          (scan.latch),
    .joy_in        (joy_in)
  );

endmodule

//--- pad_mux_latch.sv
module pad_mux_latch (
  input  logic                          clk_sys_42_95,
  input  logic                          reset,
  input  pce_pad_pkg::pad_word_t        pad_words [pce_pad_pkg::num_pads],
  pad_scan_if.latch                     scan,
  output logic [pce_pad_pkg::nibble_w-1:0] joy_in
);
  import pce_pad_pkg::*;

  // word of the addressed port
  pad_word_t port_word;
  // nibble picked by bank and select
  logic [nibble_w-1:0] nibble_next;

  always_comb begin
    if (scan.port_sel < port_w'(num_pads)) begin
      port_word = pad_words[scan.port_sel[pad_sel_w-1:0]];
    end else begin
      // unpopulated tap ports
      port_word = pad_word_t'(idle_word);
    end
  end

  // index 0 low bank, 1 dir, 2 high bank, 3 zero id nibble
  assign nibble_next = port_word.nib[{scan.high_bank, scan.dir_sel}];

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      joy_in <= '0;
    end else if (scan.clear_level) begin
      // console reads zero while clear is held
      joy_in <= '0;
    end else begin
      joy_in <= nibble_next;
    end
  end

endmodule

//--- pad_encoder.sv
module pad_encoder (
  input  logic [pce_pad_pkg::pad_buttons_w-1:0] buttons,
  input  logic                                  button6_enable,
  input  logic                                  turbo_gate_i,
  input  logic                                  turbo_gate_ii,
  output pce_pad_pkg::pad_word_t                pad_word
);
  import pce_pad_pkg::*;

  // buttons I and II after turbo merge, high means pressed
  logic fire_i;
  logic fire_ii;

  always_comb begin
    fire_i  = buttons[btn_i];
    fire_ii = buttons[btn_ii];
    // III and IV act as turbo I and II on a two-button pad
    if (!button6_enable) begin
      fire_i  = buttons[btn_i] | (turbo_gate_i & buttons[btn_iii]);
      fire_ii = buttons[btn_ii] | (turbo_gate_ii & buttons[btn_iv]);
    end
  end

  always_comb begin
    // top nibble reads as zero on a real pad
    pad_word.f.zero = '0;
    // six-button extra bank
    pad_word.f.high_bank = ~{
      buttons[btn_vi],
      buttons[btn_v],
      buttons[btn_iv],
      buttons[btn_iii]
    };
    // d-pad, console bit order
    pad_word.f.dir = ~{
      buttons[btn_left],
      buttons[btn_down],
      buttons[btn_right],
      buttons[btn_up]
    };
    // run, select, II, I
    pad_word.f.low_bank = ~{
      buttons[btn_start],
      buttons[btn_select],
      fire_ii,
      fire_i
    };
  end

endmodule

//--- turbo_timer.sv
module turbo_timer (
  input  logic       clk_sys_42_95,
  input  logic       reset,
  input  logic       frame_start,
  input  logic [1:0] button1_turbo_speed,
  input  logic [1:0] button2_turbo_speed,
  output logic       turbo_gate_i,
  output logic       turbo_gate_ii
);
  import pce_pad_pkg::*;

  // counts scan frames, wraps at 16
  logic [turbo_w-1:0] turbo_cnt;

  // gate level for one speed setting
  function automatic logic speed_gate(input logic [1:0] speed,
                                      input logic [turbo_w-1:0] cnt);
    case (speed)
      // four frames on, four off
      turbo_slow: speed_gate = cnt[2];
      // two on, two off
      turbo_fast: speed_gate = cnt[1];
      // turbo off, gate stays open
      default:    speed_gate = 1'b1;
    endcase
  endfunction

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      turbo_cnt <= '0;
    end else if (frame_start) begin
      turbo_cnt <= turbo_cnt + turbo_w'(1);
    end
  end

  assign turbo_gate_i  = speed_gate(button1_turbo_speed, turbo_cnt);
  assign turbo_gate_ii = speed_gate(button2_turbo_speed, turbo_cnt);

endmodule

//--- pad_scan_fsm.sv
module pad_scan_fsm (
  input  logic       clk_sys_42_95,
  input  logic       reset,
  input  logic       turbo_tap_enable,
  input  logic       button6_enable,
  // bit 1 clear, bit 0 select
  input  logic [1:0] joy_out,
  output logic       frame_start,
  pad_scan_if.fsm    scan
);
  import pce_pad_pkg::*;

  // previous registered levels for edge detection
  logic clear_prev;
  logic select_prev;
  logic clear_rise;
  logic select_rise;

  // edges come from the registered levels, one cycle behind the pins
  assign clear_rise  = scan.clear_level & ~clear_prev;
  assign select_rise = scan.dir_sel & ~select_prev;

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      scan.clear_level <= 1'b0;
      scan.dir_sel     <= 1'b0;
      clear_prev       <= 1'b0;
      select_prev      <= 1'b0;
      scan.port_sel    <= '0;
      scan.high_bank   <= 1'b0;
      frame_start      <= 1'b0;
    end else begin
      // sample the console lines
      scan.clear_level <= joy_out[1];
      scan.dir_sel     <= joy_out[0];
      clear_prev       <= scan.clear_level;
      select_prev      <= scan.dir_sel;

      // new scan frame on clear rising
      frame_start <= clear_rise;

      // bank flips per frame only in six-button mode
      if (clear_rise) begin
        scan.high_bank <= ~scan.high_bank & button6_enable;
      end

      // clear holds the tap at the first port
      if (scan.clear_level) begin
        scan.port_sel <= '0;
      end else if (select_rise && turbo_tap_enable) begin
        // wraps after port 7
        scan.port_sel <= scan.port_sel + port_w'(1);
      end
    end
  end

endmodule

//--- pad_scan_if.sv
interface pad_scan_if;
  import pce_pad_pkg::*;

  // port currently addressed by the console
  logic [port_w-1:0] port_sel;
  // six-button bank toggle
  logic high_bank;
  // registered clear line
  logic clear_level;
  // registered select line, picks dir or button nibble
  logic dir_sel;

  modport fsm (
    output port_sel, high_bank, clear_level, dir_sel
  );

  modport latch (
    input port_sel, high_bank, clear_level, dir_sel
  );

endinterface

//--- pce_pad_pkg.sv
package pce_pad_pkg;

  // pad count behind the multitap
  localparam int num_pads = 4;
  // index width into the pad array
  localparam int pad_sel_w = $clog2(num_pads);
  localparam int pad_buttons_w = 12;
  // console data nibble
  localparam int nibble_w = 4;
  // tap port counter, eight ports
  localparam int port_w = 3;
  // scan frame counter for turbo
  localparam int turbo_w = 4;

  // turbo speed codes, anything else means turbo off
  localparam logic [1:0] turbo_slow = 2'd1;
  localparam logic [1:0] turbo_fast = 2'd2;

  // bit positions in a pad button vector, high means pressed
  localparam int btn_right = 0;
  localparam int btn_left = 1;
  localparam int btn_down = 2;
  localparam int btn_up = 3;
  localparam int btn_i = 4;
  localparam int btn_ii = 5;
  localparam int btn_select = 6;
  localparam int btn_start = 7;
  localparam int btn_iii = 8;
  localparam int btn_iv = 9;
  localparam int btn_v = 10;
  localparam int btn_vi = 11;

  // one pad word, all fields active low
  // nib[0] low bank, nib[1] dir, nib[2] high bank, nib[3] zero
  typedef union packed {
    struct packed {
      logic [nibble_w-1:0] zero;
      logic [nibble_w-1:0] high_bank;
      logic [nibble_w-1:0] dir;
      logic [nibble_w-1:0] low_bank;
    } f;
    logic [3:0][nibble_w-1:0] nib;
  } pad_word_t;

  // empty or out of range port, nothing pressed
  localparam logic [4*nibble_w-1:0] idle_word = 16'h0FFF;

endpackage
